// File: branch_check.f
common/branch_pkg.sv
rtl/branch_write_map.sv
rtl/branch_config_store.sv
branch_eval/branch_evaluator.sv
rtl/branch_check_top.sv
verif/branch_check_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the branch_check testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f branch_check.f \
    --top-module branch_check_tb \
    -Mdir obj_dir \
    -o branch_check_sim

if ! out=$(./obj_dir/branch_check_sim 2>&1); then
    echo "$out"
    echo "Simulation exited with an error"
    exit 1
fi

echo "$out"

if echo "$out" | grep -q "^TEST OK$"; then
    exit 0
fi
exit 1

// File: verif/branch_check_tb.sv
// Uses the default map addresses and 8 threads; run length is capped by a cycle counter
`timescale 1ns/10ps

module branch_check_tb import branch_pkg::*; ();

    localparam int                    thread_count = 8;
    localparam int                    max_cycles   = 3000;
    localparam logic [addr_width-1:0] idle_addr    = 10'h000;   // Not a map address

    logic                   clock;
    logic                   rst;
    logic [pc_width-1:0]    pc;
    logic [2:0]             thread;
    logic [flags_width-1:0] flags;
    logic                   io_ready_previous;
    logic [addr_width-1:0]  write_addr;
    logic [word_width-1:0]  write_data;
    logic [2:0]             write_thread;
    logic [pc_width-1:0]    branch_destination;
    logic                   jump;
    logic                   cancel;

    // Expected result of the lookup driven this cycle and two pipe stages
    logic                exp_valid;
    logic                exp_jump;
    logic                exp_cancel;
    logic [pc_width-1:0] exp_dest;
    logic                s1_valid;
    logic                s1_jump;
    logic                s1_cancel;
    logic [pc_width-1:0] s1_dest;
    logic                s2_valid;
    logic                s2_jump;
    logic                s2_cancel;
    logic [pc_width-1:0] s2_dest;

    // Shadow of the configuration store
    branch_target_t        shadow_target [thread_count];
    branch_cond_t          shadow_cond   [thread_count];
    logic [addr_width-1:0] sw_addr;
    logic [word_width-1:0] sw_data;
    logic [2:0]            sw_thread;

    integer seed;
    string  current_test;
    int     error_count;
    int     errors_at_start;
    int     pass_count;
    int     fail_count;
    int     cycle_count;

    branch_check_top #(
        .thread_count (thread_count)
    ) i_branch_check_top (
        .clock              (clock),
        .rst                (rst),
        .pc                 (pc),
        .thread             (thread),
        .flags              (flags),
        .io_ready_previous  (io_ready_previous),
        .write_addr         (write_addr),
        .write_data         (write_data),
        .write_thread       (write_thread),
        .branch_destination (branch_destination),
        .jump               (jump),
        .cancel             (cancel)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // --------------------------------------------------------------------------
    // Reference model

    // Mapper register then store update over two edges
    always @(posedge clock) begin
        if (rst) begin
            sw_addr <= idle_addr;
            for (int i = 0; i < thread_count; i++) begin
                shadow_target[i] <= '0;
                shadow_cond[i]   <= '0;
            end
        end else begin
            sw_addr <= write_addr;
            if (sw_addr == default_target_addr) shadow_target[sw_thread] <= sw_data;
            if (sw_addr == default_cond_addr)   shadow_cond[sw_thread]   <= sw_data;
        end
        sw_data   <= write_data;
        sw_thread <= write_thread;
    end

    always @(posedge clock) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= exp_valid;
            s2_valid <= s1_valid;
        end
        {s1_jump, s1_cancel, s1_dest} <= {exp_jump, exp_cancel, exp_dest};
        {s2_jump, s2_cancel, s2_dest} <= {s1_jump, s1_cancel, s1_dest};
    end

    function automatic logic condition_holds(branch_cond_t c, logic [flags_width-1:0] f);
        logic a;
        logic b;
        a = f[c.flag_a];
        b = f[c.flag_b];
        case (c.op)
            op_always:      return 1'b1;
            op_a:           return a;
            op_not_a:       return !a;
            op_a_and_b:     return a && b;
            op_a_or_b:      return a || b;
            op_a_xor_b:     return a != b;
            op_not_a_and_b: return !a && b;
            default:        return 1'b0;   // op_never
        endcase
    endfunction

    function automatic branch_cond_t make_cond(logic [2:0] fa, logic [2:0] fb,
                                               branch_op_e op, logic pred, logic pen);
        branch_cond_t c;
        c            = '0;
        c.flag_a     = fa;
        c.flag_b     = fb;
        c.op         = op;
        c.predict    = pred;
        c.predict_en = pen;
        return c;
    endfunction

    // --------------------------------------------------------------------------
    // Output checks

    a_jump_matches : assert property (
        @(posedge clock) disable iff (rst) s2_valid |-> (jump == s2_jump)
    ) else begin
        error_count++;
        $display("ERROR %s jump expected %0b actual %0b",
                 current_test, $sampled(s2_jump), $sampled(jump));
    end

    a_cancel_matches : assert property (
        @(posedge clock) disable iff (rst) s2_valid |-> (cancel == s2_cancel)
    ) else begin
        error_count++;
        $display("ERROR %s cancel expected %0b actual %0b",
                 current_test, $sampled(s2_cancel), $sampled(cancel));
    end

    a_destination_matches : assert property (
        @(posedge clock) disable iff (rst) s2_valid |-> (branch_destination == s2_dest)
    ) else begin
        error_count++;
        $display("ERROR %s branch_destination expected %h actual %h",
                 current_test, $sampled(s2_dest), $sampled(branch_destination));
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: simulation ran %0d cycles without finishing", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // --------------------------------------------------------------------------
    // Stimulus tasks drive on the falling edge

    task automatic drive_lookup(input logic [2:0] thr, input logic [pc_width-1:0] pc_val,
                                input logic [flags_width-1:0] flag_val, input logic rdy);
        branch_target_t t;
        branch_cond_t   c;
        logic           tk;
        logic           at_origin;
        @(negedge clock);
        t         = shadow_target[thr];
        c         = shadow_cond[thr];
        tk        = condition_holds(c, flag_val);
        at_origin = (pc_val == t.origin);
        {pc, thread, flags, io_ready_previous} = {pc_val, thr, flag_val, rdy};
        write_addr = idle_addr;
        exp_valid  = 1'b1;
        exp_jump   = at_origin && rdy && tk;
        exp_cancel = at_origin && rdy && c.predict_en && (tk != c.predict);
        exp_dest   = t.destination;
    endtask

    task automatic write_word(input logic [2:0] thr, input logic [addr_width-1:0] addr,
                              input logic [word_width-1:0] data);
        @(negedge clock);
        {write_addr, write_data, write_thread} = {addr, data, thr};
        exp_valid         = 1'b0;
        io_ready_previous = 1'b0;
    endtask

    task automatic idle_cycle();
        @(negedge clock);
        write_addr        = idle_addr;
        exp_valid         = 1'b0;
        io_ready_previous = 1'b0;
    endtask

    task automatic load_entry(input logic [2:0] thr, input logic [pc_width-1:0] origin,
                              input logic [pc_width-1:0] dest, input branch_cond_t c);
        branch_target_t t;
        t.destination = dest;
        t.origin      = origin;
        write_word(thr, default_target_addr, t);
        write_word(thr, default_cond_addr, c);
        idle_cycle();   // Store holds the new entry from the next lookup on
    endtask

    task automatic start_test(input string name);
        current_test    = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        repeat (4) idle_cycle();   // Drain both lookups in flight
        if (error_count == errors_at_start) begin
            pass_count++;
            $display("%s: passed", current_test);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", current_test, error_count - errors_at_start);
        end
    endtask

    // --------------------------------------------------------------------------
    // Test sequence

    initial begin
        logic [31:0] rnd;
        seed = 32'hbcb7;
        {rst, pc, thread, flags, io_ready_previous} = '0;
        rst = 1'b1;
        {write_addr, write_data, write_thread} = {idle_addr, 20'h0, 3'd0};
        {exp_valid, exp_jump, exp_cancel, exp_dest} = '0;
        repeat (10) @(negedge clock);
        rst = 1'b0;

        start_test("reset_state");
        for (int i = 0; i < thread_count; i++) begin
            rnd = $random(seed);
            drive_lookup(i[2:0], 10'h000, rnd[7:0], 1'b1);   // Origin is zero too
            drive_lookup(i[2:0], rnd[17:8], rnd[25:18], 1'b1);
            drive_lookup(i[2:0], 10'h3ff, 8'hff, 1'b1);
        end
        end_test();

        start_test("unconditional");
        load_entry(3'd2, 10'h040, 10'h1c4, make_cond(3'd0, 3'd0, op_always, 1'b0, 1'b0));
        drive_lookup(3'd2, 10'h040, 8'h00, 1'b1);
        drive_lookup(3'd2, 10'h041, 8'h00, 1'b1);
        drive_lookup(3'd2, 10'h240, 8'h00, 1'b1);
        drive_lookup(3'd2, 10'h040, 8'h00, 1'b1);
        for (int i = 0; i < 10; i++) begin
            rnd = $random(seed);
            drive_lookup(3'd2, rnd[9:0], rnd[17:10], 1'b1);
        end
        end_test();

        start_test("flag_conditions");
        load_entry(3'd3, 10'h155, 10'h0e0, make_cond(3'd0, 3'd0, op_never, 1'b0, 1'b0));
        for (int i = 0; i < 200; i++) begin
            rnd = $random(seed);
            write_word(3'd3, default_cond_addr,
                       make_cond(rnd[2:0], rnd[5:3], branch_op_e'(i[2:0]), 1'b0, 1'b0));
            idle_cycle();
            drive_lookup(3'd3, 10'h155, rnd[13:6], 1'b1);
        end
        end_test();

        start_test("ready_qualifier");
        load_entry(3'd6, 10'h300, 10'h015, make_cond(3'd0, 3'd0, op_always, 1'b0, 1'b1));
        repeat (4) drive_lookup(3'd6, 10'h300, 8'h5a, 1'b0);
        drive_lookup(3'd6, 10'h300, 8'h5a, 1'b1);   // Jump and cancel together
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            drive_lookup(3'd6, 10'h300, rnd[7:0], 1'b0);
        end
        end_test();

        start_test("prediction");
        load_entry(3'd7, 10'h0c8, 10'h3e1, make_cond(3'd0, 3'd0, op_never, 1'b0, 1'b0));
        for (int i = 0; i < 80; i++) begin
            rnd = $random(seed);
            write_word(3'd7, default_cond_addr,
                       make_cond(rnd[2:0], rnd[5:3], branch_op_e'(rnd[8:6]), rnd[9], i[0]));
            idle_cycle();
            drive_lookup(3'd7, 10'h0c8, rnd[17:10], 1'b1);
        end
        end_test();

        start_test("map_and_threads");
        load_entry(3'd4, 10'h120, 10'h2f0, make_cond(3'd1, 3'd2, op_always, 1'b0, 1'b0));
        load_entry(3'd5, 10'h120, 10'h0aa, make_cond(3'd1, 3'd2, op_never, 1'b1, 1'b1));
        write_word(3'd4, 10'h3a2, 20'h00000);   // Unmapped address is ignored
        write_word(3'd4, 10'h1a0, 20'h00000);
        write_word(3'd5, 10'h3a3, 20'hfffff);
        idle_cycle();
        repeat (4) begin
            drive_lookup(3'd4, 10'h120, 8'h00, 1'b1);
            drive_lookup(3'd5, 10'h120, 8'h00, 1'b1);
        end
        load_entry(3'd5, 10'h2aa, 10'h101, make_cond(3'd0, 3'd0, op_always, 1'b1, 1'b1));
        repeat (4) begin
            drive_lookup(3'd4, 10'h120, 8'h00, 1'b1);
            drive_lookup(3'd5, 10'h2aa, 8'h00, 1'b1);
        end
        end_test();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/branch_check_top.sv
// Lookup outputs follow inputs by 2 cycles; a write is visible to lookups 2 cycles after it arrives
`timescale 1ns/10ps

module branch_check_top import branch_pkg::*; #(
    parameter int                    thread_count = 8,
    parameter logic [addr_width-1:0] target_addr  = default_target_addr,
    parameter logic [addr_width-1:0] cond_addr    = default_cond_addr,
    localparam int                   thread_width = (thread_count > 1) ?
                                                    $clog2(thread_count) : 1
) (
    input  logic                    clock,
    input  logic                    rst,

    // Lookup side
    input  logic [pc_width-1:0]     pc,
    input  logic [thread_width-1:0] thread,
    input  logic [flags_width-1:0]  flags,
    input  logic                    io_ready_previous,

    // ALU write side
    input  logic [addr_width-1:0]   write_addr,
    input  logic [word_width-1:0]   write_data,
    input  logic [thread_width-1:0] write_thread,

    // Resolution
    output logic [pc_width-1:0]     branch_destination,
    output logic                    jump,
    output logic                    cancel
);

    // ------------------------------------------------------------------------
    // Interconnect

    logic                    wren_target;
    logic                    wren_cond;
    logic [thread_width-1:0] map_thread;
    branch_word_u            map_data;

    branch_target_t          cfg_target;
    branch_cond_t            cfg_cond;

    // ------------------------------------------------------------------------
    // Instances

    branch_write_map #(
        .thread_count (thread_count),
        .target_addr  (target_addr),
        .cond_addr    (cond_addr)
    ) u_write_map (
        .clock        (clock),
        .rst          (rst),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .write_thread (write_thread),
        .wren_target  (wren_target),
        .wren_cond    (wren_cond),
        .map_thread   (map_thread),
        .map_data     (map_data)
    );

    branch_config_store #(
        .thread_count (thread_count)
    ) u_config_store (
        .clock        (clock),
        .rst          (rst),
        .wren_target  (wren_target),
        .wren_cond    (wren_cond),
        .map_thread   (map_thread),
        .map_data     (map_data),
        .thread       (thread),        // Read straight from the issuing thread
        .cfg_target   (cfg_target),
        .cfg_cond     (cfg_cond)
    );

    branch_evaluator u_evaluator (
        .clock              (clock),
        .rst                (rst),
        .pc                 (pc),
        .flags              (flags),
        .io_ready_previous  (io_ready_previous),
        .cfg_target         (cfg_target),
        .cfg_cond           (cfg_cond),
        .branch_destination (branch_destination),
        .jump               (jump),
        .cancel             (cancel)
    );

endmodule

// File: branch_eval/branch_evaluator.sv
// Fixed two-cycle latency, one lookup per cycle; outputs hold no state beyond the last lookup
`timescale 1ns/10ps

module branch_evaluator import branch_pkg::*; (
    input  logic                   clock,
    input  logic                   rst,

    // Issuing instruction
    input  logic [pc_width-1:0]    pc,
    input  logic [flags_width-1:0] flags,
    input  logic                   io_ready_previous,

    // Configuration of the issuing thread arrives one cycle late
    input  branch_target_t         cfg_target,
    input  branch_cond_t           cfg_cond,

    // Resolution
    output logic [pc_width-1:0]    branch_destination,
    output logic                   jump,
    output logic                   cancel
);

    // ------------------------------------------------------------------------
    // Stage 1
    // Hold the lookup inputs so they line up with the store read

    logic [pc_width-1:0]    pc_q;
    logic [flags_width-1:0] flags_q;
    logic                   ready_q;

    always_ff @(posedge clock) begin
        if (rst) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= io_ready_previous;
        end

        pc_q    <= pc;
        flags_q <= flags;
    end

    // ------------------------------------------------------------------------
    // Stage 2 decode

    logic hit;          // At the branch origin
    logic flag_a_bit;
    logic flag_b_bit;
    logic taken;        // Condition holds
    logic mispredicted;

    assign hit        = (pc_q == cfg_target.origin);
    assign flag_a_bit = flags_q[cfg_cond.flag_a];
    assign flag_b_bit = flags_q[cfg_cond.flag_b];

    // Combine the two selected flags
    always_comb begin
        taken = 1'b0;
        case (cfg_cond.op)
            op_never:       taken = 1'b0;
            op_always:      taken = 1'b1;
            op_a:           taken = flag_a_bit;
            op_not_a:       taken = ~flag_a_bit;
            op_a_and_b:     taken = flag_a_bit & flag_b_bit;
            op_a_or_b:      taken = flag_a_bit | flag_b_bit;
            op_a_xor_b:     taken = flag_a_bit ^ flag_b_bit;
            op_not_a_and_b: taken = ~flag_a_bit & flag_b_bit;
            default:        taken = 1'b0;
        endcase
    end

    // Only a static prediction that was enabled can be wrong
    assign mispredicted = cfg_cond.predict_en && (taken != cfg_cond.predict);

    // ------------------------------------------------------------------------
    // Stage 2 output register

    always_ff @(posedge clock) begin
        if (rst) begin
            jump   <= 1'b0;
            cancel <= 1'b0;
        end else begin
            jump   <= hit && ready_q && taken;
            cancel <= hit && ready_q && mispredicted;   // Flush the wrong path
        end

        branch_destination <= cfg_target.destination;  // Only meaningful with jump
    end

    // ------------------------------------------------------------------------
    // Checks

    // No cancel from an entry that has prediction switched off
    a_cancel_needs_predict : assert property (
        @(posedge clock) disable iff (rst)
        !cfg_cond.predict_en |=> !cancel
    );

endmodule

// File: rtl/branch_config_store.sv
// One target and one condition word per thread; same-cycle read and write returns the old entry
`timescale 1ns/10ps

module branch_config_store import branch_pkg::*; #(
    parameter int  thread_count = 8,
    localparam int thread_width = (thread_count > 1) ? $clog2(thread_count) : 1
) (
    input  logic                    clock,
    input  logic                    rst,

    // Write port from the mapper
    input  logic                    wren_target,
    input  logic                    wren_cond,
    input  logic [thread_width-1:0] map_thread,
    input  branch_word_u            map_data,

    // Read port, addressed by the issuing thread
    input  logic [thread_width-1:0] thread,
    output branch_target_t          cfg_target,
    output branch_cond_t            cfg_cond
);

    // ------------------------------------------------------------------------
    // Storage

    branch_target_t target_mem [thread_count];
    branch_cond_t   cond_mem   [thread_count];

    // ------------------------------------------------------------------------
    // Write port
    // Reset clears every entry, leaving all threads at op_never

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < thread_count; i++) begin
                target_mem[i] <= '0;
                cond_mem[i]   <= '0;
            end
        end else begin
            if (wren_target) begin
                target_mem[map_thread] <= map_data.target;
            end
            if (wren_cond) begin
                cond_mem[map_thread] <= map_data.cond;   // Same word through the other view
            end
        end
    end

    // ------------------------------------------------------------------------
    // Registered read port

    always_ff @(posedge clock) begin
        if (rst) begin
            cfg_target <= '0;
            cfg_cond   <= '0;
        end else begin
            cfg_target <= target_mem[thread];   // Old value on a colliding write
            cfg_cond   <= cond_mem[thread];
        end
    end

    // ------------------------------------------------------------------------
    // Checks

    // A mapped write must name an existing thread
    a_map_thread_range : assert property (
        @(posedge clock) disable iff (rst)
        (wren_target || wren_cond) |-> (map_thread < thread_count)
    );

    // Lookups only come from live threads
    a_read_thread_range : assert property (
        @(posedge clock) disable iff (rst)
        thread < thread_count
    );

endmodule

// File: rtl/branch_write_map.sv
// Unhandshaked ALU writes; writes to any address other than the two map addresses are ignored
`timescale 1ns/10ps

module branch_write_map import branch_pkg::*; #(
    parameter int                    thread_count = 8,
    parameter logic [addr_width-1:0] target_addr  = default_target_addr,
    parameter logic [addr_width-1:0] cond_addr    = default_cond_addr,
    localparam int                   thread_width = (thread_count > 1) ?
                                                    $clog2(thread_count) : 1
) (
    input  logic                    clock,
    input  logic                    rst,

    // ALU write side
    input  logic [addr_width-1:0]   write_addr,
    input  logic [word_width-1:0]   write_data,
    input  logic [thread_width-1:0] write_thread,

    // To the configuration store
    output logic                    wren_target,
    output logic                    wren_cond,
    output logic [thread_width-1:0] map_thread,
    output branch_word_u            map_data
);

    // ------------------------------------------------------------------------
    // Address decode
    // The store only sees enables

    logic hit_target;
    logic hit_cond;

    assign hit_target = (write_addr == target_addr);
    assign hit_cond   = (write_addr == cond_addr);

    // ------------------------------------------------------------------------
    // Output register one cycle after the ALU write

    always_ff @(posedge clock) begin
        if (rst) begin
            wren_target <= 1'b0;
            wren_cond   <= 1'b0;
        end else begin
            wren_target <= hit_target;
            wren_cond   <= hit_cond;
        end

        map_thread <= write_thread;            // Payload follows the enables
        map_data   <= branch_word_u'(write_data);
    end

    // ------------------------------------------------------------------------
    // Checks

    // Distinct map addresses, so the store never sees both enables at once
    a_map_addr_distinct : assert property (
        @(posedge clock) target_addr != cond_addr
    );

endmodule

// File: common/branch_pkg.sv
// Widths and map addresses are fixed here; flags_width must not exceed 2**flag_sel_width
package branch_pkg;

    // ------------------------------------------------------------------------
    // Widths

    parameter int pc_width       = 10;
    parameter int word_width     = 2 * pc_width;  // One ALU write word
    parameter int addr_width     = 10;
    parameter int flags_width    = 8;
    parameter int flag_sel_width = 3;              // Picks one of the flags bits

    // Reserved bits at the top of a condition word
    parameter int cond_rsvd_width = word_width - (2 * flag_sel_width) - 3 - 2;

    // ------------------------------------------------------------------------
    // Default memory map

    parameter logic [addr_width-1:0] default_target_addr = 10'h3a0;
    parameter logic [addr_width-1:0] default_cond_addr   = 10'h3a1;

    // ------------------------------------------------------------------------
    // Condition operations
    // Zero is op_never, so a cleared condition word never branches

    typedef enum logic [2:0] {
        op_never       = 3'd0,
        op_always      = 3'd1,
        op_a           = 3'd2,
        op_not_a       = 3'd3,
        op_a_and_b     = 3'd4,
        op_a_or_b      = 3'd5,
        op_a_xor_b     = 3'd6,
        op_not_a_and_b = 3'd7
    } branch_op_e;

    // ------------------------------------------------------------------------
    // Per-thread configuration words

    // Target word with the destination in the upper half
    typedef struct packed {
        logic [pc_width-1:0] destination;
        logic [pc_width-1:0] origin;
    } branch_target_t;

    // Condition word
    typedef struct packed {
        logic [cond_rsvd_width-1:0] reserved;   // Reads back as written
        logic [flag_sel_width-1:0]  flag_a;
        logic [flag_sel_width-1:0]  flag_b;
        branch_op_e                 op;
        logic                       predict;    // Static prediction where 1 is taken
        logic                       predict_en;
    } branch_cond_t;

    // One ALU write word read as target or condition by the address it hit
    typedef union packed {
        branch_target_t target;
        branch_cond_t   cond;
    } branch_word_u;

endpackage
